/* build.f */
logic/matmul_pkg.sv
logic/mm_sequencer.sv
logic/operand_skew.sv
logic/mac_cell.sv
logic/pe_grid.sv
logic/result_drain.sv
logic/matmul_tile.sv
tests/matmul_tile_tb.sv

/* logic/mac_cell.sv */
`timescale 1ns/1ps

module mac_cell (
  input  logic               clk,
  input  logic               i_clear,
  input  matmul_pkg::elem_t  i_a,
  input  matmul_pkg::elem_t  i_b,
  output matmul_pkg::elem_t  o_a,
  output matmul_pkg::elem_t  o_b,
  output matmul_pkg::elem_t  o_sum
);

  logic signed [2*matmul_pkg::DATA_W-1:0] prod_q;
  matmul_pkg::elem_t                      prod_sat;
  logic [matmul_pkg::DATA_W:0]            prod_top;

  // Stage 1, operand registers double as the forwarding path
  always_ff @(posedge clk) begin
    if (i_clear) begin
      o_a <= '0;
      o_b <= '0;
    end else begin
      o_a <= i_a;
      o_b <= i_b;
    end
  end

  // Stage 2, full-width signed product
  always_ff @(posedge clk) begin
    if (i_clear) begin
      prod_q <= '0;
    end else begin
      prod_q <= o_a * o_b;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Down-cast to the element range
  //////////////////////////////////////////////////////////////////////

  // Sign bit plus everything above bit DATA_W-2
  assign prod_top = prod_q[2*matmul_pkg::DATA_W-1:matmul_pkg::DATA_W-1];

  always_comb begin
    if ((&prod_top) || !(|prod_top)) begin
      // Fits, keep the low byte
      prod_sat = prod_q[matmul_pkg::DATA_W-1:0];
    end else if (prod_q[2*matmul_pkg::DATA_W-1]) begin
      // Most negative element
      prod_sat = {1'b1, {(matmul_pkg::DATA_W-1){1'b0}}};
    end else begin
      prod_sat = {1'b0, {(matmul_pkg::DATA_W-1){1'b1}}};
    end
  end

  // Stage 3, accumulator wraps at the element width
  always_ff @(posedge clk) begin
    if (i_clear) begin
      o_sum <= '0;
    end else begin
      o_sum <= o_sum + prod_sat;
    end
  end

endmodule

/* logic/matmul_pkg.sv */
package matmul_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes and widths
  //////////////////////////////////////////////////////////////////////

  // Element width of A, B and C
  localparam int DATA_W = 8;
  // Tile edge, fixed for this tile
  localparam int GRID_N = 4;
  localparam int ADDR_W = 11;
  localparam int STRIDE_W = 8;
  // Run counter, wide enough for one full run
  localparam int CNT_W = 8;

  // Pipeline depth of one MAC: operand, product, accumulate
  localparam int MAC_STAGES = 3;
  // Read latency of both operand memories
  localparam int MEM_LATENCY = 1;
  // Last term lands in the far corner cell at this count
  localparam int LATCH_CNT = 3 * GRID_N - 1 + MAC_STAGES;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  typedef logic signed [DATA_W-1:0] elem_t;
  // Lane 0 sits in the low bits
  typedef logic [GRID_N-1:0][DATA_W-1:0] lane_vec_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [STRIDE_W-1:0] stride_t;
  typedef logic [CNT_W-1:0] cnt_t;
  // One bit per lane
  typedef logic [GRID_N-1:0] mask_t;
  // Indexed [column][row], so each column of C is one lane vector
  typedef logic [GRID_N-1:0][GRID_N-1:0][DATA_W-1:0] elem_grid_t;

endpackage

/* logic/matmul_tile.sv */
`timescale 1ns/1ps

module matmul_tile (
  input  logic         clk,
  input  logic         reset,
  input  logic         i_start,
  input  logic [10:0]  i_addr_a,
  input  logic [10:0]  i_addr_b,
  input  logic [10:0]  i_addr_c,
  input  logic [7:0]   i_stride_a,
  input  logic [7:0]   i_stride_b,
  input  logic [7:0]   i_stride_c,
  // One A column or one B row per word, four 8-bit lanes
  input  logic [31:0]  i_a_data,
  input  logic [31:0]  i_b_data,
  input  logic [3:0]   i_mask_a_rows,
  input  logic [3:0]   i_mask_inner,
  input  logic [3:0]   i_mask_b_cols,
  output logic [10:0]  o_a_addr,
  output logic [10:0]  o_b_addr,
  output logic [10:0]  o_c_addr,
  output logic [31:0]  o_c_data,
  output logic         o_c_valid,
  output logic         o_done
);

  logic [7:0]   run_cnt;
  logic         operand_valid;
  logic [31:0]  a_edge;
  logic [31:0]  b_edge;
  // Sixteen sums, one 32-bit column after another
  logic [127:0] sums;

  mm_sequencer u_seq (
    .clk (clk), .reset (reset), .i_start (i_start),
    .i_addr_a (i_addr_a), .i_addr_b (i_addr_b),
    .i_stride_a (i_stride_a), .i_stride_b (i_stride_b),
    .i_mask_inner (i_mask_inner),
    .o_a_addr (o_a_addr), .o_b_addr (o_b_addr),
    .o_cnt (run_cnt), .o_operand_valid (operand_valid)
  );

  // A rows feed the left edge
  operand_skew u_skew_a (
    .clk (clk), .reset (reset), .i_start (i_start),
    .i_data (i_a_data), .i_valid (operand_valid),
    .i_lane_mask (i_mask_a_rows), .o_edge (a_edge)
  );

  // B columns feed the top edge
  operand_skew u_skew_b (
    .clk (clk), .reset (reset), .i_start (i_start),
    .i_data (i_b_data), .i_valid (operand_valid),
    .i_lane_mask (i_mask_b_cols), .o_edge (b_edge)
  );

  pe_grid u_grid (
    .clk (clk), .reset (reset), .i_start (i_start),
    .i_a_edge (a_edge), .i_b_edge (b_edge), .o_sums (sums)
  );

  result_drain u_drain (
    .clk (clk), .reset (reset), .i_start (i_start),
    .i_cnt (run_cnt), .i_sums (sums),
    .i_addr_c (i_addr_c), .i_stride_c (i_stride_c),
    .o_c_addr (o_c_addr), .o_c_data (o_c_data),
    .o_c_valid (o_c_valid), .o_done (o_done)
  );

endmodule

/* logic/mm_sequencer.sv */
`timescale 1ns/1ps

module mm_sequencer (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  i_start,
  input  matmul_pkg::addr_t     i_addr_a,
  input  matmul_pkg::addr_t     i_addr_b,
  input  matmul_pkg::stride_t   i_stride_a,
  input  matmul_pkg::stride_t   i_stride_b,
  input  matmul_pkg::mask_t     i_mask_inner,
  output matmul_pkg::addr_t     o_a_addr,
  output matmul_pkg::addr_t     o_b_addr,
  output matmul_pkg::cnt_t      o_cnt,
  output logic                  o_operand_valid
);

  matmul_pkg::cnt_t fetch_idx;
  matmul_pkg::cnt_t word_idx;
  logic             addr_step;
  logic             in_window;

  // Run counter, cleared whenever the start level drops
  always_ff @(posedge clk) begin
    if (reset || !i_start) begin
      o_cnt <= '0;
    end else begin
      o_cnt <= o_cnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read address generation
  //////////////////////////////////////////////////////////////////////

  // Base is out after edge 1, then one stride per edge through edge GRID_N
  assign addr_step = (o_cnt >= 1) && (o_cnt < matmul_pkg::GRID_N);

  always_ff @(posedge clk) begin
    if (reset || !i_start) begin
      o_a_addr <= i_addr_a;
      o_b_addr <= i_addr_b;
    end else if (addr_step) begin
      o_a_addr <= o_a_addr + matmul_pkg::addr_t'(i_stride_a);
      o_b_addr <= o_b_addr + matmul_pkg::addr_t'(i_stride_b);
    end
  end

  // Cycles since the first read, stops once the last word is back
  always_ff @(posedge clk) begin
    if (reset || !i_start) begin
      fetch_idx <= '0;
    end else if ((o_cnt >= 1) &&
                 (fetch_idx < matmul_pkg::GRID_N + matmul_pkg::MEM_LATENCY)) begin
      fetch_idx <= fetch_idx + 1'b1;
    end
  end

  // Word k returns MEM_LATENCY cycles after its address
  assign word_idx  = fetch_idx - matmul_pkg::cnt_t'(matmul_pkg::MEM_LATENCY);
  assign in_window = (fetch_idx >= matmul_pkg::MEM_LATENCY) &&
                     (fetch_idx < matmul_pkg::GRID_N + matmul_pkg::MEM_LATENCY);
  // One valid for A and B, the inner mask drops whole terms
  assign o_operand_valid = in_window &&
                           i_mask_inner[word_idx[$clog2(matmul_pkg::GRID_N)-1:0]];

  // A running count must not roll over before the drain is done
  assert property (@(posedge clk) disable iff (reset)
    (i_start && o_cnt != '0) |=> (o_cnt != '0));

endmodule

/* logic/operand_skew.sv */
`timescale 1ns/1ps

module operand_skew (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   i_start,
  input  matmul_pkg::lane_vec_t  i_data,
  input  logic                   i_valid,
  input  matmul_pkg::mask_t      i_lane_mask,
  output wire matmul_pkg::lane_vec_t o_edge
);

  matmul_pkg::lane_vec_t masked;

  // Zero lanes outside the fetch window or outside the lane mask
  always_comb begin
    for (int i = 0; i < matmul_pkg::GRID_N; i++) begin
      masked[i] = (i_valid && i_lane_mask[i]) ? i_data[i] : '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Triangular delay, lane i waits i cycles
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < matmul_pkg::GRID_N; i++) begin : g_lane
    if (i == 0) begin : g_direct
      // Lane 0 enters the grid edge straight away
      assign o_edge[i] = masked[i];
    end else begin : g_delay
      logic [matmul_pkg::DATA_W-1:0] pipe [i];

      // Cleared between runs so the wavefront starts from zeros
      always_ff @(posedge clk) begin
        if (reset || !i_start) begin
          for (int j = 0; j < i; j++) begin
            pipe[j] <= '0;
          end
        end else begin
          pipe[0] <= masked[i];
          for (int j = 1; j < i; j++) begin
            pipe[j] <= pipe[j-1];
          end
        end
      end

      assign o_edge[i] = pipe[i-1];
    end
  end

endmodule

/* logic/pe_grid.sv */
`timescale 1ns/1ps

module pe_grid (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   i_start,
  input  matmul_pkg::lane_vec_t  i_a_edge,
  input  matmul_pkg::lane_vec_t  i_b_edge,
  output wire matmul_pkg::elem_grid_t o_sums
);

  logic              cell_clear;
  // A travels right along a row, B travels down a column
  matmul_pkg::elem_t a_h [matmul_pkg::GRID_N][matmul_pkg::GRID_N+1];
  matmul_pkg::elem_t b_v [matmul_pkg::GRID_N+1][matmul_pkg::GRID_N];

  // One clear for every cell, also between runs
  assign cell_clear = reset || !i_start;

  for (genvar r = 0; r < matmul_pkg::GRID_N; r++) begin : g_row
    assign a_h[r][0] = matmul_pkg::elem_t'(i_a_edge[r]);

    for (genvar c = 0; c < matmul_pkg::GRID_N; c++) begin : g_col
      if (r == 0) begin : g_top
        assign b_v[0][c] = matmul_pkg::elem_t'(i_b_edge[c]);
      end

      mac_cell u_cell (
        .clk     (clk),
        .i_clear (cell_clear),
        .i_a     (a_h[r][c]),
        .i_b     (b_v[r][c]),
        .o_a     (a_h[r][c+1]),
        .o_b     (b_v[r+1][c]),
        .o_sum   (o_sums[c][r])
      );
    end
  end

  // Every accumulator is empty once a clear has gone through
  assert property (@(posedge clk) cell_clear |=> (o_sums == '0));

endmodule

/* logic/result_drain.sv */
`timescale 1ns/1ps

module result_drain (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    i_start,
  input  matmul_pkg::cnt_t        i_cnt,
  input  matmul_pkg::elem_grid_t  i_sums,
  input  matmul_pkg::addr_t       i_addr_c,
  input  matmul_pkg::stride_t     i_stride_c,
  output matmul_pkg::addr_t       o_c_addr,
  output matmul_pkg::lane_vec_t   o_c_data,
  output logic                    o_c_valid,
  output logic                    o_done
);

  matmul_pkg::lane_vec_t               col_q [matmul_pkg::GRID_N];
  logic [$clog2(matmul_pkg::GRID_N)-1:0] col_idx;
  logic                                latch_en;
  logic                                last_col;

  // All cells hold their final sums at this count
  assign latch_en = (i_cnt == matmul_pkg::cnt_t'(matmul_pkg::LATCH_CNT));
  assign last_col = (col_idx == matmul_pkg::GRID_N - 1);

  //////////////////////////////////////////////////////////////////////
  // Column shift chain
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (latch_en) begin
      for (int j = 0; j < matmul_pkg::GRID_N; j++) begin
        col_q[j] <= i_sums[j];
      end
    end else if (o_c_valid) begin
      // Next column moves to the head each cycle
      for (int j = 0; j < matmul_pkg::GRID_N - 1; j++) begin
        col_q[j] <= col_q[j+1];
      end
    end
  end

  assign o_c_data = col_q[0];

  // Write control, one column per cycle then a done strobe
  always_ff @(posedge clk) begin
    if (reset || !i_start) begin
      o_c_valid <= 1'b0;
      o_done    <= 1'b0;
      col_idx   <= '0;
      o_c_addr  <= i_addr_c;
    end else if (latch_en) begin
      o_c_valid <= 1'b1;
      col_idx   <= '0;
      o_c_addr  <= i_addr_c;
    end else if (o_c_valid) begin
      if (last_col) begin
        o_c_valid <= 1'b0;
        o_done    <= 1'b1;
      end else begin
        col_idx  <= col_idx + 1'b1;
        o_c_addr <= o_c_addr + matmul_pkg::addr_t'(i_stride_c);
      end
    end else begin
      o_done <= 1'b0;
    end
  end

  // Nothing is written or finished unless a run is active
  assert property (@(posedge clk) disable iff (reset)
    !i_start |=> !(o_c_valid || o_done));
  // Done follows the last column and never overlaps it
  assert property (@(posedge clk) disable iff (reset) !(o_c_valid && o_done));

endmodule

/* run.sh */
#!/bin/sh
# Build and run the matmul tile regression with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module matmul_tile_tb -o matmul_tile_sim; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/matmul_tile_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Regression passed"; then
  exit 0
fi
exit 1

/* tests/matmul_tile_tb.sv */
`timescale 1ns/1ps

module matmul_tile_tb;

  localparam int CLK_PERIOD = 8;
  localparam int NUM_CASES = 8;
  localparam int N = matmul_pkg::GRID_N;

  logic clk = 1'b0;
  logic reset;
  logic i_start;
  matmul_pkg::addr_t i_addr_a, i_addr_b, i_addr_c;
  matmul_pkg::stride_t i_stride_a, i_stride_b, i_stride_c;
  matmul_pkg::lane_vec_t i_a_data, i_b_data;
  matmul_pkg::mask_t i_mask_a_rows, i_mask_inner, i_mask_b_cols;
  matmul_pkg::addr_t o_a_addr, o_b_addr, o_c_addr;
  matmul_pkg::lane_vec_t o_c_data;
  logic o_c_valid;
  logic o_done;

  // Case table, bases and strides are indexed 0 for A, 1 for B, 2 for C
  string case_name [NUM_CASES];
  matmul_pkg::mask_t case_rows [NUM_CASES];
  matmul_pkg::mask_t case_inner [NUM_CASES];
  matmul_pkg::mask_t case_cols [NUM_CASES];
  matmul_pkg::addr_t case_base [NUM_CASES][3];
  matmul_pkg::stride_t case_stride [NUM_CASES][3];
  matmul_pkg::elem_t case_a [NUM_CASES][N][N];
  matmul_pkg::elem_t case_b [NUM_CASES][N][N];

  // Operand memories and their registered read addresses
  matmul_pkg::lane_vec_t mem_a [2**matmul_pkg::ADDR_W];
  matmul_pkg::lane_vec_t mem_b [2**matmul_pkg::ADDR_W];
  matmul_pkg::addr_t a_rd_addr;
  matmul_pkg::addr_t b_rd_addr;

  integer seed = 32'hcd90_c593;
  int error_count = 0;
  int pass_count = 0;
  int fail_count = 0;
  int current_case = -1;

  matmul_tile dut0 (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Memory models, one cycle read latency
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    a_rd_addr = o_a_addr;
    b_rd_addr = o_b_addr;
  end

  // Word for the address seen in the last cycle
  always @(posedge clk) begin
    #1;
    i_a_data = mem_a[a_rd_addr];
    i_b_data = mem_b[b_rd_addr];
  end

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_column(input matmul_pkg::lane_vec_t got,
                              input matmul_pkg::lane_vec_t exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic check_addr(input matmul_pkg::addr_t got,
                            input matmul_pkg::addr_t exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
      error_count++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Case table and reference model
  //////////////////////////////////////////////////////////////////////

  // Kind 0 identity times a ramp, 1 random, 2 saturating, 3 signed extremes
  task automatic set_case(input int idx, input string name, input int kind,
                          input matmul_pkg::mask_t rows, input matmul_pkg::mask_t inner,
                          input matmul_pkg::mask_t cols, input int ba, input int bb,
                          input int bc, input int sa, input int sb, input int sc);
    int a;
    int b;
    case_name[idx] = name;
    case_rows[idx] = rows;
    case_inner[idx] = inner;
    case_cols[idx] = cols;
    case_base[idx] = '{matmul_pkg::addr_t'(ba), matmul_pkg::addr_t'(bb),
                       matmul_pkg::addr_t'(bc)};
    case_stride[idx] = '{matmul_pkg::stride_t'(sa), matmul_pkg::stride_t'(sb),
                         matmul_pkg::stride_t'(sc)};
    for (int i = 0; i < N; i++) begin
      for (int k = 0; k < N; k++) begin
        case (kind)
          0: begin
            a = (i == k) ? 1 : 0;
            b = i * N + k - 7;
          end
          2: begin
            a = 100;
            b = (k % 2) ? -100 : 100;
          end
          3: begin
            a = ((i + k) % 2) ? -128 : 127;
            b = ((i + k) % 3 == 0) ? -128 : 90;
          end
          default: begin
            a = $random(seed);
            b = $random(seed);
          end
        endcase
        case_a[idx][i][k] = matmul_pkg::elem_t'(a);
        case_b[idx][i][k] = matmul_pkg::elem_t'(b);
      end
    end
  endtask

  // C[i][j] sums clamped products, masked terms drop out, sum wraps at 8 bits
  function automatic matmul_pkg::elem_grid_t reference_c(input int idx);
    matmul_pkg::elem_grid_t c;
    matmul_pkg::elem_t acc;
    int prod;
    c = '0;
    for (int i = 0; i < N; i++) begin
      for (int j = 0; j < N; j++) begin
        acc = '0;
        for (int k = 0; k < N; k++) begin
          if (case_rows[idx][i] && case_cols[idx][j] && case_inner[idx][k]) begin
            prod = int'(case_a[idx][i][k]) * int'(case_b[idx][k][j]);
            prod = (prod > 127) ? 127 : ((prod < -128) ? -128 : prod);
            acc = acc + matmul_pkg::elem_t'(prod);
          end
        end
        c[j][i] = acc;
      end
    end
    return c;
  endfunction

  // Background words follow the address, then A columns and B rows go on top
  task automatic load_memories(input int idx);
    matmul_pkg::addr_t addr;
    for (int w = 0; w < 2**matmul_pkg::ADDR_W; w++) begin
      addr = matmul_pkg::addr_t'(w);
      mem_a[w] = {addr, 10'h155, addr};
      mem_b[w] = ~{addr, 10'h0aa, addr};
    end
    for (int k = 0; k < N; k++) begin
      for (int i = 0; i < N; i++) begin
        addr = case_base[idx][0] + matmul_pkg::addr_t'(k * case_stride[idx][0]);
        mem_a[addr][i] = case_a[idx][i][k];
        addr = case_base[idx][1] + matmul_pkg::addr_t'(k * case_stride[idx][1]);
        mem_b[addr][i] = case_b[idx][k][i];
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // One run of the tile
  //////////////////////////////////////////////////////////////////////

  task automatic run_case(input int idx);
    matmul_pkg::elem_grid_t exp_c;
    matmul_pkg::addr_t exp_addr;
    int cols;
    int cyc;
    int errors_before;
    bit done_seen;
    errors_before = error_count;
    current_case = idx;
    load_memories(idx);
    exp_c = reference_c(idx);
    cols = 0;
    cyc = 0;
    done_seen = 1'b0;
    // Settings go out one cycle ahead of start so the bases load
    @(posedge clk);
    #1;
    i_addr_a = case_base[idx][0];
    i_addr_b = case_base[idx][1];
    i_addr_c = case_base[idx][2];
    i_stride_a = case_stride[idx][0];
    i_stride_b = case_stride[idx][1];
    i_stride_c = case_stride[idx][2];
    i_mask_a_rows = case_rows[idx];
    i_mask_inner = case_inner[idx];
    i_mask_b_cols = case_cols[idx];
    @(posedge clk);
    #1;
    i_start = 1'b1;
    while (!done_seen) begin
      @(negedge clk);
      // Read k goes out after edge k+1 of the run
      if ((cyc >= 1) && (cyc <= N)) begin
        exp_addr = case_base[idx][0] + matmul_pkg::addr_t'((cyc - 1) * case_stride[idx][0]);
        check_addr(o_a_addr, exp_addr,
                   $sformatf("case %0d A read %0d address", idx, cyc - 1));
        exp_addr = case_base[idx][1] + matmul_pkg::addr_t'((cyc - 1) * case_stride[idx][1]);
        check_addr(o_b_addr, exp_addr,
                   $sformatf("case %0d B read %0d address", idx, cyc - 1));
      end
      check_flag(o_c_valid && o_done, 1'b0, "o_c_valid together with o_done");
      if (o_c_valid) begin
        if (cols < N) begin
          exp_addr = case_base[idx][2] + matmul_pkg::addr_t'(cols * case_stride[idx][2]);
          check_addr(o_c_addr, exp_addr, $sformatf("case %0d column %0d address", idx, cols));
          check_column(o_c_data, exp_c[cols], $sformatf("case %0d column %0d", idx, cols));
        end
        cols++;
      end
      if (o_done) begin
        done_seen = 1'b1;
        if (cols != N) begin
          $display("Case %0d raised done after %0d columns instead of %0d", idx, cols, N);
          error_count++;
        end
      end
      cyc++;
    end
    // Done is a one cycle strobe, then the tile stays quiet with start low
    @(posedge clk);
    #1;
    i_start = 1'b0;
    repeat (2) begin
      @(negedge clk);
      check_flag(o_done, 1'b0, "o_done after the strobe");
      check_flag(o_c_valid, 1'b0, "o_c_valid after the run");
    end
    if (error_count == errors_before) begin
      pass_count++;
      $display("case %0d %s: ok", idx, case_name[idx]);
    end else begin
      fail_count++;
      $display("case %0d %s: FAILED with %0d errors", idx, case_name[idx],
               error_count - errors_before);
    end
  endtask

  initial begin
    reset = 1'b1;
    i_start = 1'b0;
    i_addr_a = '0;
    i_addr_b = '0;
    i_addr_c = '0;
    i_stride_a = '0;
    i_stride_b = '0;
    i_stride_c = '0;
    i_a_data = '0;
    i_b_data = '0;
    i_mask_a_rows = '0;
    i_mask_inner = '0;
    i_mask_b_cols = '0;
    set_case(0, "identity x ramp", 0, 4'b1111, 4'b1111, 4'b1111,
             'h000, 'h100, 'h200, 1, 1, 1);
    set_case(1, "random full masks", 1, 4'b1111, 4'b1111, 4'b1111,
             'h013, 'h345, 'h7fa, 3, 7, 5);
    set_case(2, "saturate both ways", 2, 4'b1111, 4'b1111, 4'b1111,
             'h020, 'h020, 'h100, 1, 1, 1);
    set_case(3, "signed extremes", 3, 4'b1111, 4'b1111, 4'b1111,
             'h7f0, 'h000, 'h300, 4, 9, 2);
    set_case(4, "row and column masks", 1, 4'b1011, 4'b1111, 4'b0110,
             'h100, 'h200, 'h300, 1, 1, 1);
    set_case(5, "inner mask", 1, 4'b1111, 4'b1010, 4'b1111,
             'h055, 'h066, 'h077, 2, 2, 2);
    set_case(6, "all masks wide strides", 1, 4'b0111, 4'b1101, 4'b1110,
             'h000, 'h001, 'h400, 128, 200, 255);
    set_case(7, "random stride two", 1, 4'b1111, 4'b1111, 4'b1111,
             'h3fe, 'h2fd, 'h010, 2, 2, 3);
    // Outputs stay low all through reset
    repeat (10) begin
      @(negedge clk);
      check_flag(o_c_valid, 1'b0, "o_c_valid in reset");
      check_flag(o_done, 1'b0, "o_done in reset");
    end
    @(posedge clk);
    #1;
    reset = 1'b0;
    for (int t = 0; t < NUM_CASES; t++) begin
      run_case(t);
    end
    $display("%0d cases passed, %0d failed, %0d errors", pass_count, fail_count, error_count);
    if (error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Forty cycles per case plus the reset window
  initial begin
    #((NUM_CASES * 40 + 20) * CLK_PERIOD);
    $display("Run timed out at %0t while case %0d was running", $time, current_case);
    $display("Regression failed");
    $finish;
  end

endmodule
